//--- bench/rv_alu_patterns.hex
// columns: ctrl rs1 rs2 pc imm exp_res exp_add
// ctrl nibbles: op, {opa_mux opb_mux unsigned}, funct3, funct7_5, trig, trap, exp_cmp, 0
00000020 00001234 00005678 00001000 00000010 000068ac 000068ac
06000010 00000000 00000000 80000ffc 00000008 80001004 80001004
00000020 ffffffff 00000002 00000000 00000000 00000001 00000001
02000000 7fffffff 00000005 00000000 00000001 80000000 80000000
10000020 00000010 00000020 00000000 00000000 fffffff0 fffffff0
16000010 0000abcd 0000abcd 00002000 00000004 00001ffc 00001ffc
30000020 ffffff00 00000001 00000000 00000000 00000001 fffffeff
31000000 ffffff00 00000001 00000000 00000000 00000000 fffffeff
31000020 00000005 80000000 00000000 00000000 00000001 80000005
30000000 00000005 80000000 00000000 00000000 00000000 80000005
50000020 f0f0a5a5 0ff05a5a 00000000 00000000 ff00ffff 00e0ffff
62000010 00ff0000 00ff0000 00000000 0000ff00 00ffff00 00ffff00
70000000 12345678 0f0f0f0f 00000000 00000000 02040608 21436587
42000010 00000001 00000001 00000000 deadbeef deadbeef deadbef0
22101020 8000000f 00000000 00000000 00000004 000000f0 80000013
22101010 a5a5a5a5 a5a5a5a5 00000000 00000000 a5a5a5a5 a5a5a5a5
22501020 80000000 00000001 00000000 0000001f 00000001 8000001f
22511020 80000000 00000001 00000000 0000001f ffffffff 8000001f
22511010 f0000f00 f0000f00 00000000 00000008 fff0000f f0000f08
20502020 cafef00d 00000000 00000000 00000000 00000000 cafef00d
20502020 cafef00d 00000003 00000000 00000000 cafef00d cafef010
20702000 13579bdf 00000000 00000000 00000000 13579bdf 13579bdf
20702010 13579bdf 13579bdf 00000000 00000000 00000000 26af37be
22501110 ffffffff ffffffff 00000000 0000001f 00000000 0000001e
22101010 00000001 00000001 00000000 00000001 00000002 00000002

//--- rv_alu.f
verilog/rv_alu_pkg.sv
verilog/rv_alu_prefix_adder.sv
verilog/rv_alu_shifter.sv
verilog/rv_alu_cond_unit.sv
verilog/rv_alu_result_sel.sv
verilog/rv_alu_cp_ctrl.sv
verilog/rv_alu_top.sv
bench/rv_alu_tb.sv

//--- Makefile
# Verilator build and run for the rv_alu testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = rv_alu_tb
FILELIST = rv_alu.f
OBJ_DIR  = obj_dir
PASS_MSG = Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass message
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/rv_alu_tb.sv
// ------------------------------------------------
// rv_alu testbench
// replays the pattern file against the alu top,
// combinational ops and co-processor runs
// ------------------------------------------------
module rv_alu_tb;

    localparam int NUM_VEC   = 25;                   // vectors in the pattern file
    localparam int VEC_WORDS = 7;                    // ctrl rs1 rs2 pc imm res add
    localparam int MAX_CYC   = NUM_VEC * 80 + 20;    // watchdog limit
    localparam int TRAP_WAIT = 40;                   // longer than a 31-bit shift

    logic        clk_i = 1'b0;
    logic        rstn_i;
    logic [2:0]  alu_op_i;
    logic        opa_mux_i;
    logic        opb_mux_i;
    logic        unsigned_i;
    logic [2:0]  funct3_i;
    logic        funct7_5_i;
    logic [1:0]  cp_trig_i;
    logic        cpu_trap_i;
    logic [31:0] rs1_i;
    logic [31:0] rs2_i;
    logic [31:0] pc_i;
    logic [31:0] imm_i;
    logic [1:0]  cmp_o;
    logic [31:0] res_o;
    logic [31:0] add_o;
    logic        exc_o;
    logic        cp_done_o;

    logic [31:0] pat_mem [0:NUM_VEC*VEC_WORDS-1];    // flat vector words
    int          cycle_cnt = 0;

    rv_alu_top u_dut (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .alu_op_i   (alu_op_i),
        .opa_mux_i  (opa_mux_i),
        .opb_mux_i  (opb_mux_i),
        .unsigned_i (unsigned_i),
        .funct3_i   (funct3_i),
        .funct7_5_i (funct7_5_i),
        .cp_trig_i  (cp_trig_i),
        .cpu_trap_i (cpu_trap_i),
        .rs1_i      (rs1_i),
        .rs2_i      (rs2_i),
        .pc_i       (pc_i),
        .imm_i      (imm_i),
        .cmp_o      (cmp_o),
        .res_o      (res_o),
        .add_o      (add_o),
        .exc_o      (exc_o),
        .cp_done_o  (cp_done_o)
    );

    always #4 clk_i = ~clk_i;                        // 8 unit period

    // ------------------------------------------------
    // watchdog
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYC) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYC);
            $display("Simulation failed");
            $fatal(1, "run stopped by watchdog");
        end
    end

    task automatic check(input string name, input logic [31:0] exp_val,
                         input logic [31:0] act_val);
        if (act_val !== exp_val) begin
            $display("error: %s expected %h actual %h", name, exp_val, act_val);
            $display("Simulation failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // no timeout exception anywhere in the run
    always @(negedge clk_i) begin
        if (rstn_i) begin
            check("exc_o low", 32'h0, 32'(exc_o));
        end
    end

    task automatic check_outputs(input int idx, input logic [31:0] exp_res,
                                 input logic [1:0] exp_cmp, input logic [31:0] exp_add);
        check($sformatf("vec %0d res_o", idx), exp_res, res_o);
        check($sformatf("vec %0d cmp_o", idx), 32'(exp_cmp), 32'(cmp_o));
        check($sformatf("vec %0d add_o", idx), exp_add, add_o);
    endtask

    // ------------------------------------------------
    // drive one vector, wait for the result and compare
    task automatic run_vector(input int idx);
        logic [31:0] ctrl;
        logic [31:0] exp_res;
        logic [31:0] exp_add;
        logic [1:0]  trig;
        logic        trap;
        ctrl    = pat_mem[idx*VEC_WORDS];
        exp_res = pat_mem[idx*VEC_WORDS+5];
        exp_add = pat_mem[idx*VEC_WORDS+6];
        trig    = ctrl[13:12];
        trap    = ctrl[8];

        @(posedge clk_i);
        alu_op_i   <= ctrl[30:28];
        opa_mux_i  <= ctrl[26];
        opb_mux_i  <= ctrl[25];
        unsigned_i <= ctrl[24];
        funct3_i   <= ctrl[22:20];
        funct7_5_i <= ctrl[16];
        cp_trig_i  <= trig;
        rs1_i      <= pat_mem[idx*VEC_WORDS+1];
        rs2_i      <= pat_mem[idx*VEC_WORDS+2];
        pc_i       <= pat_mem[idx*VEC_WORDS+3];
        imm_i      <= pat_mem[idx*VEC_WORDS+4];

        if (trig == '0) begin
            @(posedge clk_i);                        // comb paths settled
        end else begin
            @(posedge clk_i);
            cp_trig_i  <= '0;                        // single-cycle start
            cpu_trap_i <= trap;
            if (trap) begin
                @(posedge clk_i);
                cpu_trap_i <= 1'b0;
                // aborted shift must stay silent
                repeat (TRAP_WAIT) begin
                    @(negedge clk_i);
                    check($sformatf("vec %0d cp_done_o after trap", idx),
                          32'h0, 32'(cp_done_o));
                end
            end else begin
                do begin
                    @(negedge clk_i);
                end while (cp_done_o !== 1'b1);      // valid pulse seen mid cycle
            end
        end
        check_outputs(idx, exp_res, ctrl[5:4], exp_add);
        repeat (2) @(posedge clk_i);                 // monitor back to idle
    endtask

    // ------------------------------------------------
    // main sequence
    initial begin
        rstn_i     = 1'b0;
        alu_op_i   = '0;
        opa_mux_i  = 1'b0;
        opb_mux_i  = 1'b0;
        unsigned_i = 1'b0;
        funct3_i   = '0;
        funct7_5_i = 1'b0;
        cp_trig_i  = '0;
        cpu_trap_i = 1'b0;
        rs1_i      = '0;
        rs2_i      = '0;
        pc_i       = '0;
        imm_i      = '0;

        $readmemh("bench/rv_alu_patterns.hex", pat_mem);
        if ($isunknown(pat_mem[0]) || (pat_mem[0] == '0)) begin
            $display("pattern file did not load");
            $display("Simulation failed");
            $fatal(1, "no stimulus");
        end

        repeat (5) @(posedge clk_i);
        rstn_i <= 1'b1;
        @(negedge clk_i);
        check("reset cp_done_o", 32'h0, 32'(cp_done_o));
        check("reset exc_o", 32'h0, 32'(exc_o));

        for (int i = 0; i < NUM_VEC; i++) begin
            run_vector(i);
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

//--- verilog/rv_alu_top.sv
// ------------------------------------------------
// rv_alu top level
// integer alu with shift and conditional-zero
// co-processors, wiring only
// ------------------------------------------------
module rv_alu_top (
    input  logic                                clk_i,      // rising edge
    input  logic                                rstn_i,     // async, low active
    input  logic [rv_alu_pkg::ALU_OP_W-1:0]     alu_op_i,   // alu operation
    input  logic                                opa_mux_i,  // 1 = pc
    input  logic                                opb_mux_i,  // 1 = imm
    input  logic                                unsigned_i, // unsigned compare/extend
    input  logic [2:0]                          funct3_i,
    input  logic                                funct7_5_i, // arith right shift
    input  logic [rv_alu_pkg::CP_NUM-1:0]       cp_trig_i,  // one-cycle start pulse
    input  logic                                cpu_trap_i, // abort cp operation
    input  logic [rv_alu_pkg::XLEN-1:0]         rs1_i,
    input  logic [rv_alu_pkg::XLEN-1:0]         rs2_i,
    input  logic [rv_alu_pkg::XLEN-1:0]         pc_i,
    input  logic [rv_alu_pkg::XLEN-1:0]         imm_i,
    output logic [1:0]                          cmp_o,      // branch status
    output logic [rv_alu_pkg::XLEN-1:0]         res_o,      // alu result
    output logic [rv_alu_pkg::XLEN-1:0]         add_o,      // address result
    output logic                                exc_o,      // cp timeout
    output logic                                cp_done_o   // cp result valid
);

    logic [rv_alu_pkg::XLEN-1:0]   opa;        // adder operand a
    logic [rv_alu_pkg::XLEN-1:0]   opb;        // adder / logic operand b
    logic                          sub_en;
    logic [rv_alu_pkg::XLEN:0]     addsub_res; // 33-bit, top bit = less
    logic [rv_alu_pkg::XLEN-1:0]   cp_res;     // merged cp result
    logic [rv_alu_pkg::XLEN-1:0]   shift_res;
    logic [rv_alu_pkg::XLEN-1:0]   cond_res;
    logic [rv_alu_pkg::CP_NUM-1:0] cp_valid;

    assign add_o = addsub_res[rv_alu_pkg::XLEN-1:0]; // direct address path

    rv_alu_result_sel u_result_sel (
        .alu_op_i     (alu_op_i),
        .opa_mux_i    (opa_mux_i),
        .opb_mux_i    (opb_mux_i),
        .unsigned_i   (unsigned_i),
        .rs1_i        (rs1_i),
        .rs2_i        (rs2_i),
        .pc_i         (pc_i),
        .imm_i        (imm_i),
        .addsub_res_i (addsub_res),
        .cp_res_i     (cp_res),
        .opa_o        (opa),
        .opb_o        (opb),
        .sub_en_o     (sub_en),
        .cmp_o        (cmp_o),
        .res_o        (res_o)
    );

    rv_alu_prefix_adder u_adder (
        .opa_i        (opa),
        .opb_i        (opb),
        .sub_en_i     (sub_en),
        .unsigned_i   (unsigned_i),
        .addsub_res_o (addsub_res)
    );

    rv_alu_shifter u_shifter (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .start_i    (cp_trig_i[rv_alu_pkg::CP_SEL_SHIFT]),
        .cpu_trap_i (cpu_trap_i),
        .funct3_i   (funct3_i),
        .funct7_5_i (funct7_5_i),
        .rs1_i      (rs1_i),
        .shamt_i    (opb[rv_alu_pkg::SHAMT_W-1:0]), // reg or imm amount
        .res_o      (shift_res),
        .valid_o    (cp_valid[rv_alu_pkg::CP_SEL_SHIFT])
    );

    rv_alu_cond_unit u_cond (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .start_i  (cp_trig_i[rv_alu_pkg::CP_SEL_COND]),
        .funct3_i (funct3_i),
        .rs1_i    (rs1_i),
        .rs2_i    (rs2_i),
        .res_o    (cond_res),
        .valid_o  (cp_valid[rv_alu_pkg::CP_SEL_COND])
    );

    rv_alu_cp_ctrl u_cp_ctrl (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .cp_trig_i   (cp_trig_i),
        .cpu_trap_i  (cpu_trap_i),
        .cp_valid_i  (cp_valid),
        .shift_res_i (shift_res),
        .cond_res_i  (cond_res),
        .cp_res_o    (cp_res),
        .cp_done_o   (cp_done_o),
        .exc_o       (exc_o)
    );

endmodule

//--- verilog/rv_alu_cp_ctrl.sv
// ------------------------------------------------
// co-processor control
// run/finish monitor with timeout exception,
// done flag and result merge
// ------------------------------------------------
module rv_alu_cp_ctrl (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  logic [rv_alu_pkg::CP_NUM-1:0] cp_trig_i,   // start pulses
    input  logic                          cpu_trap_i,  // abort
    input  logic [rv_alu_pkg::CP_NUM-1:0] cp_valid_i,  // finish pulses
    input  logic [rv_alu_pkg::XLEN-1:0]   shift_res_i, // zero unless valid
    input  logic [rv_alu_pkg::XLEN-1:0]   cond_res_i,  // zero unless valid
    output logic [rv_alu_pkg::XLEN-1:0]   cp_res_o,
    output logic                          cp_done_o,
    output logic                          exc_o        // timeout
);

    logic                                run; // cp operation in flight
    logic                                fin; // valid seen last cycle
    logic [rv_alu_pkg::CP_TIMEOUT_W-1:0] cnt; // cycles since start

    // ------------------------------------------------
    // monitor that catches a hung co-processor
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            run   <= 1'b0;
            fin   <= 1'b0;
            cnt   <= '0;
            exc_o <= 1'b0;
        end else begin
            exc_o <= run & (&cnt[rv_alu_pkg::CP_TIMEOUT_W-1 -: 3]) & ~fin; // limit hit
            fin   <= |cp_valid_i;
            if (!run) begin
                cnt <= '0;
                if (|cp_trig_i) begin
                    run <= 1'b1;                // start tracking
                end
            end else begin
                cnt <= cnt + 1'b1;              // new triggers ignored here
                if (fin || cpu_trap_i) begin
                    run <= 1'b0;                // done or aborted
                end
            end
        end
    end

    assign cp_done_o = |cp_valid_i;               // any cp finished
    assign cp_res_o  = shift_res_i | cond_res_i;  // idle units drive zero

    // ------------------------------------------------
    // protocol checks across the cp units
    a_trig_onehot : assert property (@(posedge clk_i) disable iff (!rstn_i)
        $onehot0(cp_trig_i))
        else $error("more than one co-processor triggered");

    a_valid_onehot : assert property (@(posedge clk_i) disable iff (!rstn_i)
        $onehot0(cp_valid_i))
        else $error("more than one co-processor valid");

endmodule

//--- verilog/rv_alu_result_sel.sv
// ------------------------------------------------
// operand select, branch comparator, logic ops
// and final alu result multiplexer
// ------------------------------------------------
module rv_alu_result_sel (
    input  logic [rv_alu_pkg::ALU_OP_W-1:0] alu_op_i,
    input  logic                            opa_mux_i,    // 1 = pc
    input  logic                            opb_mux_i,    // 1 = imm
    input  logic                            unsigned_i,
    input  logic [rv_alu_pkg::XLEN-1:0]     rs1_i,
    input  logic [rv_alu_pkg::XLEN-1:0]     rs2_i,
    input  logic [rv_alu_pkg::XLEN-1:0]     pc_i,
    input  logic [rv_alu_pkg::XLEN-1:0]     imm_i,
    input  logic [rv_alu_pkg::XLEN:0]       addsub_res_i, // from adder
    input  logic [rv_alu_pkg::XLEN-1:0]     cp_res_i,     // merged cp result
    output logic [rv_alu_pkg::XLEN-1:0]     opa_o,
    output logic [rv_alu_pkg::XLEN-1:0]     opb_o,
    output logic                            sub_en_o,
    output logic [1:0]                      cmp_o,
    output logic [rv_alu_pkg::XLEN-1:0]     res_o
);

    logic [rv_alu_pkg::XLEN:0] cmp_rs1; // optionally sign-extended
    logic [rv_alu_pkg::XLEN:0] cmp_rs2;

    // ------------------------------------------------
    // comparator, rs1 against rs2 for branches
    assign cmp_rs1 = {rs1_i[rv_alu_pkg::XLEN-1] & ~unsigned_i, rs1_i};
    assign cmp_rs2 = {rs2_i[rv_alu_pkg::XLEN-1] & ~unsigned_i, rs2_i};

    assign cmp_o[rv_alu_pkg::CMP_EQUAL] = (rs1_i == rs2_i);
    assign cmp_o[rv_alu_pkg::CMP_LESS]  = ($signed(cmp_rs1) < $signed(cmp_rs2)); // 33-bit signed

    // operand select
    assign opa_o = opa_mux_i ? pc_i  : rs1_i;
    assign opb_o = opb_mux_i ? imm_i : rs2_i;

    // subtract for sub and slt
    assign sub_en_o = (alu_op_i == rv_alu_pkg::ALU_OP_SUB)
                    | (alu_op_i == rv_alu_pkg::ALU_OP_SLT);

    // ------------------------------------------------
    // result select
    always_comb begin
        case (alu_op_i)
            rv_alu_pkg::ALU_OP_ADD,
            rv_alu_pkg::ALU_OP_SUB:  res_o = addsub_res_i[rv_alu_pkg::XLEN-1:0];
            rv_alu_pkg::ALU_OP_CP:   res_o = cp_res_i;       // valid with cp_done
            rv_alu_pkg::ALU_OP_SLT:  res_o = {{(rv_alu_pkg::XLEN-1){1'b0}},
                                              addsub_res_i[rv_alu_pkg::XLEN]}; // less flag
            rv_alu_pkg::ALU_OP_MOVB: res_o = opb_o;
            rv_alu_pkg::ALU_OP_XOR:  res_o = rs1_i ^ opb_o;
            rv_alu_pkg::ALU_OP_OR:   res_o = rs1_i | opb_o;
            rv_alu_pkg::ALU_OP_AND:  res_o = rs1_i & opb_o;
            default:                 res_o = addsub_res_i[rv_alu_pkg::XLEN-1:0];
        endcase
    end

endmodule

//--- verilog/rv_alu_cond_unit.sv
// ------------------------------------------------
// conditional-zero co-processor
// czero.eqz / czero.nez, one cycle latency
// ------------------------------------------------
module rv_alu_cond_unit (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        start_i,  // trigger pulse
    input  logic [2:0]                  funct3_i,
    input  logic [rv_alu_pkg::XLEN-1:0] rs1_i,
    input  logic [rv_alu_pkg::XLEN-1:0] rs2_i,
    output logic [rv_alu_pkg::XLEN-1:0] res_o,
    output logic                        valid_o
);

    logic                        rs2_zero; // condition operand is zero
    logic                        clear;    // result forced to zero
    logic [rv_alu_pkg::XLEN-1:0] res_q;

    assign rs2_zero = (rs2_i == '0);
    assign clear    = ((funct3_i == rv_alu_pkg::F3_CZERO_EQZ) &  rs2_zero)
                    | ((funct3_i == rv_alu_pkg::F3_CZERO_NEZ) & ~rs2_zero);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= start_i; // single-cycle pulse
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            res_q <= clear ? '0 : rs1_i;
        end
    end

    assign res_o = valid_o ? res_q : '0; // zero unless valid

endmodule

//--- verilog/rv_alu_shifter.sv
// ------------------------------------------------
// iterative shift co-processor
// sll, srl and sra, one bit position per cycle
// ------------------------------------------------
module rv_alu_shifter (
    input  logic                           clk_i,
    input  logic                           rstn_i,
    input  logic                           start_i,    // trigger pulse
    input  logic                           cpu_trap_i, // abandon operation
    input  logic [2:0]                     funct3_i,
    input  logic                           funct7_5_i, // arith right shift
    input  logic [rv_alu_pkg::XLEN-1:0]    rs1_i,
    input  logic [rv_alu_pkg::SHAMT_W-1:0] shamt_i,
    output logic [rv_alu_pkg::XLEN-1:0]    res_o,
    output logic                           valid_o
);

    logic                           busy;    // shifting in progress
    logic                           done;    // result ready this cycle
    logic [rv_alu_pkg::SHAMT_W-1:0] cnt;     // remaining positions
    logic                           left_q;  // sll
    logic                           arith_q; // sra, fill with sign
    logic [rv_alu_pkg::XLEN-1:0]    sreg;    // word being shifted

    // ------------------------------------------------
    // sequencing
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= 1'b0;
            if (cpu_trap_i) begin
                busy <= 1'b0;                   // abort, no valid
            end else if (start_i) begin
                busy <= 1'b1;
                cnt  <= shamt_i;
            end else if (busy) begin
                if (cnt == '0) begin
                    busy <= 1'b0;
                    done <= 1'b1;               // shamt+1 cycles after start
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end
        end
    end

    // data path
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            sreg    <= rs1_i;
            left_q  <= (funct3_i == rv_alu_pkg::F3_SLL);
            arith_q <= (funct3_i == rv_alu_pkg::F3_SR) & funct7_5_i;
        end else if (busy && (cnt != '0)) begin
            sreg <= left_q ? {sreg[rv_alu_pkg::XLEN-2:0], 1'b0}
                           : {arith_q & sreg[rv_alu_pkg::XLEN-1], sreg[rv_alu_pkg::XLEN-1:1]};
        end
    end

    assign valid_o = done;
    assign res_o   = done ? sreg : '0; // zero outside the valid cycle

    a_no_start_busy : assert property (@(posedge clk_i) disable iff (!rstn_i)
        start_i |-> !busy)
        else $error("shifter started while busy");

endmodule

//--- verilog/rv_alu_prefix_adder.sv
// ------------------------------------------------
// 33-bit prefix adder/subtractor
// kogge-stone style carry tree, top sum bit
// serves as the less-than flag
// ------------------------------------------------
module rv_alu_prefix_adder (
    input  logic [rv_alu_pkg::XLEN-1:0] opa_i,
    input  logic [rv_alu_pkg::XLEN-1:0] opb_i,
    input  logic                        sub_en_i,    // invert b, carry in
    input  logic                        unsigned_i,  // zero- instead of sign-extend
    output logic [rv_alu_pkg::XLEN:0]   addsub_res_o
);

    logic [rv_alu_pkg::XLEN:0]   opa_x;  // extended operand a
    logic [rv_alu_pkg::XLEN:0]   opb_x;  // extended, maybe inverted b
    logic [rv_alu_pkg::XLEN:0]   carry;  // carry into each bit
    logic [rv_alu_pkg::XLEN-1:0] p0;     // bit propagate
    logic [rv_alu_pkg::XLEN-1:0] g0;     // bit generate, cin folded in

    // group terms per tree level, level 0 = bit level
    logic [rv_alu_pkg::XLEN-1:0] g_lvl [0:$clog2(rv_alu_pkg::XLEN)];
    logic [rv_alu_pkg::XLEN-1:0] p_lvl [0:$clog2(rv_alu_pkg::XLEN)];

    // ------------------------------------------------
    // operand prep
    assign opa_x = {opa_i[rv_alu_pkg::XLEN-1] & ~unsigned_i, opa_i};
    assign opb_x = {opb_i[rv_alu_pkg::XLEN-1] & ~unsigned_i, opb_i}
                   ^ {(rv_alu_pkg::XLEN+1){sub_en_i}}; // ones complement for sub

    assign p0 = opa_x[rv_alu_pkg::XLEN-1:0] ^ opb_x[rv_alu_pkg::XLEN-1:0];
    assign g0 = opa_x[rv_alu_pkg::XLEN-1:0] & opb_x[rv_alu_pkg::XLEN-1:0];

    assign g_lvl[0] = {g0[rv_alu_pkg::XLEN-1:1], g0[0] | (p0[0] & sub_en_i)}; // carry in
    assign p_lvl[0] = p0;

    // ------------------------------------------------
    // prefix tree, distances 1, 2, 4, 8, 16
    for (genvar lvl = 1; lvl <= $clog2(rv_alu_pkg::XLEN); lvl++) begin : g_tree
        // bits below the distance keep their group value
        assign g_lvl[lvl] = g_lvl[lvl-1]
                          | (p_lvl[lvl-1] & (g_lvl[lvl-1] << (1 << (lvl - 1))));
        assign p_lvl[lvl] = p_lvl[lvl-1] & (p_lvl[lvl-1] << (1 << (lvl - 1)));
    end

    // ------------------------------------------------
    // final carry stage and sum
    assign carry = {g_lvl[$clog2(rv_alu_pkg::XLEN)], sub_en_i}; // bit i gets cout of i-1

    assign addsub_res_o = opa_x ^ opb_x ^ carry; // bit 32 = sign of 33-bit result

endmodule

//--- verilog/rv_alu_pkg.sv
// ------------------------------------------------
// rv_alu shared definitions
// widths, op codes, funct3 codes, status indices
// ------------------------------------------------
package rv_alu_pkg;

    // ------------------------------------------------
    // widths
    localparam int XLEN     = 32;                // data path width
    localparam int SHAMT_W  = 5;                 // shift amount width
    localparam int ALU_OP_W = 3;                 // alu op code width

    // ------------------------------------------------
    // alu op codes, sub and slt carry bit 0 set
    localparam logic [ALU_OP_W-1:0] ALU_OP_ADD  = 3'b000; // opa + opb
    localparam logic [ALU_OP_W-1:0] ALU_OP_SUB  = 3'b001; // opa - opb
    localparam logic [ALU_OP_W-1:0] ALU_OP_CP   = 3'b010; // co-processor result
    localparam logic [ALU_OP_W-1:0] ALU_OP_SLT  = 3'b011; // set if less than
    localparam logic [ALU_OP_W-1:0] ALU_OP_MOVB = 3'b100; // pass operand b
    localparam logic [ALU_OP_W-1:0] ALU_OP_XOR  = 3'b101; // rs1 ^ opb
    localparam logic [ALU_OP_W-1:0] ALU_OP_OR   = 3'b110; // rs1 | opb
    localparam logic [ALU_OP_W-1:0] ALU_OP_AND  = 3'b111; // rs1 & opb

    // ------------------------------------------------
    // funct3 codes seen by the co-processors
    localparam logic [2:0] F3_SLL       = 3'b001; // shift left logical
    localparam logic [2:0] F3_SR        = 3'b101; // shift right, funct7[5] picks arith
    localparam logic [2:0] F3_CZERO_EQZ = 3'b101; // zero if rs2 == 0
    localparam logic [2:0] F3_CZERO_NEZ = 3'b111; // zero if rs2 != 0

    // comparator status bits
    localparam int CMP_EQUAL = 0;                // rs1 == rs2
    localparam int CMP_LESS  = 1;                // rs1 < rs2

    // ------------------------------------------------
    // co-processors
    localparam int CP_NUM       = 2;             // number of co-processors
    localparam int CP_SEL_SHIFT = 0;             // iterative shifter
    localparam int CP_SEL_COND  = 1;             // conditional zero
    localparam int CP_TIMEOUT_W = 6;             // monitor counter width

endpackage
